// ==== common/spi_cfg.svh ====
`ifndef SPI_CFG_SVH
`define SPI_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Frame and sample sizing
////////////////////////////////////////////////////////////////////////////

// Command byte plus two read bytes
`define SPI_FRAME_BYTES 3

// Half-period divider width
`define SPI_DIV_W 16

// One ADC sample, built from the two read bytes
`define SPI_SAMPLE_W 16

`endif

// ==== common/spi_pkg.sv ====
`include "spi_cfg.svh"

package spi_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Bus level types
	////////////////////////////////////////////////////////////////////////////

	// Clock polarity and phase, shared by both channels
	typedef struct packed {
		logic cpol;
		logic cpha;
	} spi_mode_t;

	// Outgoing pins of one SPI bus; miso comes back separately
	typedef struct packed {
		logic cs_n;
		logic dclk;
		logic mosi;
	} spi_bus_t;

	////////////////////////////////////////////////////////////////////////////
	// Sample types
	////////////////////////////////////////////////////////////////////////////

	// Valid is a single-cycle pulse at the end of a frame
	typedef struct packed {
		logic [`SPI_SAMPLE_W-1:0] data;
		logic                     valid;
	} chan_sample_t;

	typedef struct packed {
		logic [7:0]               tag;
		logic [`SPI_SAMPLE_W-1:0] ch0;
		logic [`SPI_SAMPLE_W-1:0] ch1;
	} sample_pair_t;

endpackage

// ==== spi_master/spi_master.sv ====
`include "spi_cfg.svh"

module spi_master
(
	input  logic                  sys_clk,
	input  logic                  rst,
	input  spi_pkg::spi_mode_t    mode,
	input  logic [`SPI_DIV_W-1:0] clk_div,
	input  logic                  wr_req,
	input  logic [7:0]            data_in,
	input  logic                  miso,
	output logic                  wr_ack,
	output logic [7:0]            data_out,
	output logic                  dclk,
	output logic                  mosi
);

	typedef enum logic [2:0] {
		ST_IDLE      = 3'd0,
		ST_EDGE      = 3'd1,
		ST_HALF_WAIT = 3'd2,
		ST_ACK       = 3'd3,
		ST_LAST_HALF = 3'd4,
		ST_ACK_WAIT  = 3'd5
	} state_t;

	state_t                state;
	state_t                next_state;
	logic                  dclk_q;
	logic [7:0]            mosi_shift;
	logic [7:0]            miso_shift;
	logic [`SPI_DIV_W-1:0] clk_cnt;
	logic [4:0]            edge_cnt;
	logic                  half_done;
	logic                  tx_shift_en;
	logic                  rx_shift_en;

	assign mosi     = mosi_shift[7];
	assign dclk     = dclk_q;
	assign data_out = miso_shift;
	assign wr_ack   = (state == ST_ACK);

	assign half_done = (clk_cnt == clk_div);

	// Edge numbering is 1-based, so edge_cnt even means an odd edge
	// cpha 0 samples on odd edges and shifts on even ones, cpha 1 the reverse
	assign rx_shift_en = mode.cpha ? edge_cnt[0] : ~edge_cnt[0];
	assign tx_shift_en = mode.cpha ? (edge_cnt != 5'd0 && !edge_cnt[0]) : edge_cnt[0];

	////////////////////////////////////////////////////////////////////////////
	// Byte FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk or posedge rst)
	begin
		if (rst)
			state <= ST_IDLE;
		else
			state <= next_state;
	end

	always_comb
	begin
		next_state = state;
		case (state)
			ST_IDLE:
				if (wr_req)
					next_state = ST_HALF_WAIT;
			// Half a dclk period between edges
			ST_HALF_WAIT:
				if (half_done)
					next_state = ST_EDGE;
			// 16 edges make one byte
			ST_EDGE:
				if (edge_cnt == 5'd15)
					next_state = ST_LAST_HALF;
				else
					next_state = ST_HALF_WAIT;
			ST_LAST_HALF:
				if (half_done)
					next_state = ST_ACK;
			ST_ACK:
				next_state = ST_ACK_WAIT;
			// One spare cycle so the requester can drop wr_req
			ST_ACK_WAIT:
				next_state = ST_IDLE;
			default:
				next_state = ST_IDLE;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Clock generation
	////////////////////////////////////////////////////////////////////////////

	// Idle level follows cpol
	always_ff @(posedge sys_clk or posedge rst)
	begin
		if (rst)
			dclk_q <= 1'b0;
		else if (state == ST_IDLE)
			dclk_q <= mode.cpol;
		else if (state == ST_EDGE)
			dclk_q <= ~dclk_q;
	end

	always_ff @(posedge sys_clk or posedge rst)
	begin
		if (rst)
			clk_cnt <= '0;
		else if (state == ST_HALF_WAIT || state == ST_LAST_HALF)
			clk_cnt <= clk_cnt + 1'b1;
		else
			clk_cnt <= '0;
	end

	always_ff @(posedge sys_clk or posedge rst)
	begin
		if (rst)
			edge_cnt <= 5'd0;
		else if (state == ST_EDGE)
			edge_cnt <= edge_cnt + 5'd1;
		else if (state == ST_IDLE)
			edge_cnt <= 5'd0;
	end

	////////////////////////////////////////////////////////////////////////////
	// Data shifters, MSB first
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk or posedge rst)
	begin
		if (rst)
			mosi_shift <= 8'd0;
		else if (state == ST_IDLE && wr_req)
			mosi_shift <= data_in;
		else if (state == ST_EDGE && tx_shift_en)
			mosi_shift <= {mosi_shift[6:0], mosi_shift[7]};
	end

	always_ff @(posedge sys_clk or posedge rst)
	begin
		if (rst)
			miso_shift <= 8'd0;
		else if (state == ST_IDLE && wr_req)
			miso_shift <= 8'd0;
		else if (state == ST_EDGE && rx_shift_en)
			miso_shift <= {miso_shift[6:0], miso};
	end

endmodule

// ==== design/spi_frame_reader.sv ====
`include "spi_cfg.svh"

module spi_frame_reader
(
	input  logic                  sys_clk,
	input  logic                  rst,
	input  logic                  start,
	input  spi_pkg::spi_mode_t    mode,
	input  logic [7:0]            cmd,
	input  logic [`SPI_DIV_W-1:0] clk_div,
	input  logic                  miso,
	output spi_pkg::spi_bus_t     bus,
	output spi_pkg::chan_sample_t sample
);

	localparam int CNT_W = $clog2(`SPI_FRAME_BYTES + 1);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_XFER,
		ST_NEXT
	} state_t;

	state_t                   state;
	logic                     cs_n;
	logic                     wr_req;
	logic                     wr_ack;
	logic [7:0]               tx_byte;
	logic [7:0]               rx_byte;
	logic [CNT_W-1:0]         byte_cnt;
	logic                     last_byte;
	logic [`SPI_SAMPLE_W-1:0] assembly;
	logic                     sample_valid;
	logic                     m_dclk;
	logic                     m_mosi;

	assign last_byte = (byte_cnt == CNT_W'(`SPI_FRAME_BYTES - 1));

	assign bus    = '{cs_n: cs_n, dclk: m_dclk, mosi: m_mosi};
	assign sample = '{data: assembly, valid: sample_valid};

	////////////////////////////////////////////////////////////////////////////
	// Frame sequencing
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk or posedge rst)
	begin
		if (rst)
		begin
			state        <= ST_IDLE;
			cs_n         <= 1'b1;
			wr_req       <= 1'b0;
			byte_cnt     <= '0;
			sample_valid <= 1'b0;
		end
		else
		begin
			sample_valid <= 1'b0;
			case (state)
				ST_IDLE:
					if (start)
					begin
						cs_n     <= 1'b0;
						wr_req   <= 1'b1;
						byte_cnt <= '0;
						state    <= ST_XFER;
					end
				ST_XFER:
					if (wr_ack)
					begin
						wr_req   <= 1'b0;
						byte_cnt <= byte_cnt + 1'b1;
						if (last_byte)
						begin
							cs_n         <= 1'b1;
							sample_valid <= 1'b1;
							state        <= ST_IDLE;
						end
						else
							state <= ST_NEXT;
					end
				// Master sits in its ack wait here, request goes up again
				ST_NEXT:
				begin
					wr_req <= 1'b1;
					state  <= ST_XFER;
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// Command first, then zero filler bytes
	always_ff @(posedge sys_clk)
	begin
		if (state == ST_IDLE && start)
			tx_byte <= cmd;
		else if (state == ST_NEXT)
			tx_byte <= 8'd0;
	end

	// The command-phase byte falls out of the top after three shifts
	always_ff @(posedge sys_clk)
	begin
		if (state == ST_XFER && wr_ack)
			assembly <= {assembly[`SPI_SAMPLE_W-9:0], rx_byte};
	end

	spi_master spi_master_i
	(
		.sys_clk  (sys_clk),
		.rst      (rst),
		.mode     (mode),
		.clk_div  (clk_div),
		.wr_req   (wr_req),
		.data_in  (tx_byte),
		.miso     (miso),
		.wr_ack   (wr_ack),
		.data_out (rx_byte),
		.dclk     (m_dclk),
		.mosi     (m_mosi)
	);

endmodule

// ==== design/sample_pair_merge.sv ====
`include "spi_cfg.svh"

module sample_pair_merge
(
	input  logic                  sys_clk,
	input  logic                  rst,
	input  logic                  start,
	input  spi_pkg::chan_sample_t ch0,
	input  spi_pkg::chan_sample_t ch1,
	output spi_pkg::sample_pair_t pair,
	output logic                  pair_valid,
	output logic                  busy
);

	logic                     got0;
	logic                     got1;
	logic [`SPI_SAMPLE_W-1:0] hold0;
	logic [`SPI_SAMPLE_W-1:0] hold1;
	logic [`SPI_SAMPLE_W-1:0] sel0;
	logic [`SPI_SAMPLE_W-1:0] sel1;
	logic [7:0]               tag;
	logic                     fire;

	// A sample arriving this cycle counts as already captured
	assign fire = busy & (got0 | ch0.valid) & (got1 | ch1.valid);
	assign sel0 = ch0.valid ? ch0.data : hold0;
	assign sel1 = ch1.valid ? ch1.data : hold1;

	////////////////////////////////////////////////////////////////////////////
	// Capture flags, busy and tag
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge sys_clk or posedge rst)
	begin
		if (rst)
		begin
			busy       <= 1'b0;
			got0       <= 1'b0;
			got1       <= 1'b0;
			pair_valid <= 1'b0;
			tag        <= 8'd0;
		end
		else
		begin
			pair_valid <= fire;
			if (start)
			begin
				busy <= 1'b1;
				got0 <= 1'b0;
				got1 <= 1'b0;
			end
			else
			begin
				if (fire)
				begin
					got0 <= 1'b0;
					got1 <= 1'b0;
					tag  <= tag + 8'd1;
				end
				else
				begin
					if (ch0.valid)
						got0 <= 1'b1;
					if (ch1.valid)
						got1 <= 1'b1;
				end
				// Drop one cycle after the pair goes out
				if (pair_valid)
					busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge sys_clk)
	begin
		if (ch0.valid)
			hold0 <= ch0.data;
		if (ch1.valid)
			hold1 <= ch1.data;
		if (fire)
			pair <= '{tag: tag, ch0: sel0, ch1: sel1};
	end

endmodule

// ==== design/dual_adc_reader.sv ====
`include "spi_cfg.svh"

module dual_adc_reader
(
	input  logic                  sys_clk,
	input  logic                  rst,
	input  logic                  start,
	input  spi_pkg::spi_mode_t    mode,
	input  logic [7:0]            cmd,
	input  logic [`SPI_DIV_W-1:0] div0,
	input  logic [`SPI_DIV_W-1:0] div1,
	input  logic                  miso0,
	input  logic                  miso1,
	output spi_pkg::spi_bus_t     bus0,
	output spi_pkg::spi_bus_t     bus1,
	output spi_pkg::sample_pair_t pair,
	output logic                  pair_valid,
	output logic                  busy
);

	spi_pkg::chan_sample_t sample0;
	spi_pkg::chan_sample_t sample1;
	logic                  go;

	// Start is dropped while a pair is in flight
	assign go = start & ~busy;

	spi_frame_reader reader0_i
	(
		.sys_clk (sys_clk),
		.rst     (rst),
		.start   (go),
		.mode    (mode),
		.cmd     (cmd),
		.clk_div (div0),
		.miso    (miso0),
		.bus     (bus0),
		.sample  (sample0)
	);

	spi_frame_reader reader1_i
	(
		.sys_clk (sys_clk),
		.rst     (rst),
		.start   (go),
		.mode    (mode),
		.cmd     (cmd),
		.clk_div (div1),
		.miso    (miso1),
		.bus     (bus1),
		.sample  (sample1)
	);

	sample_pair_merge merge_i
	(
		.sys_clk    (sys_clk),
		.rst        (rst),
		.start      (go),
		.ch0        (sample0),
		.ch1        (sample1),
		.pair       (pair),
		.pair_valid (pair_valid),
		.busy       (busy)
	);

endmodule

// ==== testbench/spi_adc_model.sv ====
module spi_adc_model
(
	input  logic               cs_n,
	input  logic               dclk,
	input  logic               mosi,
	input  spi_pkg::spi_mode_t mode,
	input  logic [15:0]        preset,
	output logic               miso,
	output logic [7:0]         cmd_seen
);

	// One zero byte ahead of the sample, plus a spare bit for phase alignment
	logic [24:0] out_sr;
	logic [7:0]  in_sr;
	logic        cs_q;
	logic        dclk_q;
	logic        sample_edge;
	int          edges;

	assign miso = out_sr[24];

	initial
	begin
		out_sr   = '0;
		in_sr    = '0;
		cmd_seen = '0;
		cs_q     = 1'b1;
		dclk_q   = 1'b0;
		edges    = 0;
	end

	////////////////////////////////////////////////////////////////////////////
	// Slave shifting, edge roles follow the current mode
	////////////////////////////////////////////////////////////////////////////

	always @(cs_n or dclk)
	begin
		if (cs_n !== cs_q)
		begin
			if (cs_n === 1'b0)
			begin
				edges = 0;
				in_sr = '0;
				// cpha 0 shows the first bit right away, cpha 1 on edge 1
				if (mode.cpha)
					out_sr = {9'd0, preset};
				else
					out_sr = {8'd0, preset, 1'b0};
			end
			else if (cs_n === 1'b1)
				cmd_seen = in_sr;
			cs_q = cs_n;
		end
		else if (dclk !== dclk_q && cs_n === 1'b0)
		begin
			edges = edges + 1;
			// Odd edges sample for cpha 0, even edges for cpha 1
			sample_edge = (edges % 2 == 1) ^ mode.cpha;
			if (sample_edge)
			begin
				if (edges <= 16)
					in_sr = {in_sr[6:0], mosi};
			end
			else
				out_sr = out_sr << 1;
		end
		dclk_q = dclk;
	end

endmodule

// ==== testbench/tb_dual_adc_reader.sv ====
module tb_dual_adc_reader;

	logic                  sys_clk;
	logic                  rst;
	logic                  start;
	spi_pkg::spi_mode_t    mode;
	logic [7:0]            cmd;
	logic [15:0]           div0;
	logic [15:0]           div1;
	logic                  miso0;
	logic                  miso1;
	spi_pkg::spi_bus_t     bus0;
	spi_pkg::spi_bus_t     bus1;
	spi_pkg::sample_pair_t pair;
	logic                  pair_valid;
	logic                  busy;
	logic [15:0]           preset0;
	logic [15:0]           preset1;
	logic [7:0]            cmd_seen0;
	logic [7:0]            cmd_seen1;
	logic [31:0]           rng_state;
	logic [7:0]            exp_tag;

	dual_adc_reader dual_adc_reader_i
	(
		.sys_clk    (sys_clk),
		.rst        (rst),
		.start      (start),
		.mode       (mode),
		.cmd        (cmd),
		.div0       (div0),
		.div1       (div1),
		.miso0      (miso0),
		.miso1      (miso1),
		.bus0       (bus0),
		.bus1       (bus1),
		.pair       (pair),
		.pair_valid (pair_valid),
		.busy       (busy)
	);

	spi_adc_model adc0_i
	(
		.cs_n     (bus0.cs_n),
		.dclk     (bus0.dclk),
		.mosi     (bus0.mosi),
		.mode     (mode),
		.preset   (preset0),
		.miso     (miso0),
		.cmd_seen (cmd_seen0)
	);

	spi_adc_model adc1_i
	(
		.cs_n     (bus1.cs_n),
		.dclk     (bus1.dclk),
		.mosi     (bus1.mosi),
		.mode     (mode),
		.preset   (preset1),
		.miso     (miso1),
		.cmd_seen (cmd_seen1)
	);

	initial
	begin
		sys_clk = 1'b0;
		forever
			#5 sys_clk = ~sys_clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
		assert (expected === actual)
		else
		begin
			$display("ERROR: time %0t %s expected %0h actual %0h", $time, name, expected, actual);
			$display("Testbench failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic check_true(logic cond, string what);
		assert (cond)
		else
		begin
			$display("Failure at time %0t: %s", $time, what);
			$display("Testbench failed");
			$fatal(1, "stopped at first failure");
		end
	endtask

	// One frame on both buses, optionally with a second start while busy
	task automatic run_frame(logic [1:0] m, logic [15:0] d0, logic [15:0] d1, logic extra);
		int       cyc;
		int       rise0;
		int       rise1;
		int       pv_cyc;
		int       latest;
		logic     cs0_prev;
		logic     cs1_prev;
		logic     dclk0_prev;
		logic     dclk1_prev;
		begin
			mode    = '{cpol: m[1], cpha: m[0]};
			div0    = d0;
			div1    = d1;
			cmd     = 8'(next_rand());
			preset0 = 16'(next_rand());
			preset1 = 16'(next_rand());
			@(posedge sys_clk);
			#1 start = 1'b1;
			@(posedge sys_clk);
			#1 start = 1'b0;
			check_value("busy", 1, 32'(busy));
			check_value("bus0.cs_n", 0, 32'(bus0.cs_n));
			check_value("bus1.cs_n", 0, 32'(bus1.cs_n));
			cyc        = 0;
			rise0      = -1;
			rise1      = -1;
			pv_cyc     = -1;
			cs0_prev   = bus0.cs_n;
			cs1_prev   = bus1.cs_n;
			dclk0_prev = bus0.dclk;
			dclk1_prev = bus1.dclk;
			while (pv_cyc < 0)
			begin
				@(posedge sys_clk);
				#1;
				cyc = cyc + 1;
				check_true(cyc < 2000, "timeout waiting for pair_valid");
				// Clock may only move inside chip select
				check_true(!(cs0_prev && bus0.cs_n && bus0.dclk != dclk0_prev),
					"dclk0 toggled while cs0_n was high");
				check_true(!(cs1_prev && bus1.cs_n && bus1.dclk != dclk1_prev),
					"dclk1 toggled while cs1_n was high");
				if (!cs0_prev && bus0.cs_n)
				begin
					rise0 = cyc;
					check_value("bus0.dclk", 32'(m[1]), 32'(bus0.dclk));
				end
				if (!cs1_prev && bus1.cs_n)
				begin
					rise1 = cyc;
					check_value("bus1.dclk", 32'(m[1]), 32'(bus1.dclk));
				end
				if (pair_valid)
				begin
					pv_cyc = cyc;
					check_value("pair.tag", 32'(exp_tag), 32'(pair.tag));
					check_value("pair.ch0", 32'(preset0), 32'(pair.ch0));
					check_value("pair.ch1", 32'(preset1), 32'(pair.ch1));
					exp_tag = exp_tag + 8'd1;
					// Both readers are idle but busy is still high
					start = extra;
				end
				cs0_prev   = bus0.cs_n;
				cs1_prev   = bus1.cs_n;
				dclk0_prev = bus0.dclk;
				dclk1_prev = bus1.dclk;
			end
			check_true(rise0 > 0 && rise1 > 0, "pair_valid before both frames ended");
			latest = (rise0 > rise1) ? rise0 : rise1;
			check_value("pair_valid cycle", latest + 1, pv_cyc);
			// Quiet period, no second frame and no second pair
			for (int i = 0; i < 40; i++)
			begin
				@(posedge sys_clk);
				#1 start = 1'b0;
				check_value("pair_valid", 0, 32'(pair_valid));
				check_value("bus0.cs_n", 1, 32'(bus0.cs_n));
				check_value("bus1.cs_n", 1, 32'(bus1.cs_n));
				check_value("busy", 0, 32'(busy));
			end
			check_value("cmd_seen0", 32'(cmd), 32'(cmd_seen0));
			check_value("cmd_seen1", 32'(cmd), 32'(cmd_seen1));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		logic [15:0] da;
		logic [15:0] db;
		rst       = 1'b1;
		start     = 1'b0;
		mode      = '0;
		cmd       = 8'd0;
		div0      = 16'd0;
		div1      = 16'd0;
		preset0   = 16'd0;
		preset1   = 16'd0;
		rng_state = 32'hd12c6339;
		exp_tag   = 8'd0;
		repeat (10)
			@(posedge sys_clk);
		#1 rst = 1'b0;

		check_value("busy", 0, 32'(busy));
		check_value("pair_valid", 0, 32'(pair_valid));
		check_value("bus0.cs_n", 1, 32'(bus0.cs_n));
		check_value("bus1.cs_n", 1, 32'(bus1.cs_n));
		check_value("bus0.dclk", 0, 32'(bus0.dclk));
		check_value("bus1.dclk", 0, 32'(bus1.dclk));

		// Idle clock level follows cpol
		for (int m = 0; m < 4; m++)
		begin
			mode = m[1:0];
			repeat (3)
				@(posedge sys_clk);
			#1;
			check_value("bus0.dclk", 32'(mode.cpol), 32'(bus0.dclk));
			check_value("bus1.dclk", 32'(mode.cpol), 32'(bus1.dclk));
		end

		for (int m = 0; m < 4; m++)
		begin
			da = 16'(next_rand() % 6);
			db = 16'(next_rand() % 6);
			run_frame(m[1:0], da, db, 1'b0);
			run_frame(m[1:0], da, da, 1'b0);
			da = 16'(next_rand() % 6);
			db = 16'(next_rand() % 6);
			run_frame(m[1:0], da, db, 1'b1);
		end

		$display("Testbench passed");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+common
common/spi_pkg.sv
spi_master/spi_master.sv
design/spi_frame_reader.sv
design/sample_pair_merge.sv
design/dual_adc_reader.sv
testbench/spi_adc_model.sv
testbench/tb_dual_adc_reader.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, then search the log

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -f src.f --top-module tb_dual_adc_reader \
	-o tb_sim > build.log 2>&1 &&
./obj_dir/tb_sim > sim.log 2>&1 ||
echo "simulation returned an error"

cat sim.log 2>/dev/null

grep -qx "Testbench passed" sim.log && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }
